// ==== logic/rv_bus_arb.sv ====
`timescale 1ns/1ps

module rv_bus_arb
    import rv_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  bus_req_t    i_ireq,
    input  bus_req_t    i_dreq,
    input  logic        i_wb_ack,
    output addr_t       o_wb_adr,
    output xlen_t       o_wb_dat,
    output logic        o_wb_we,
    output byte_sel_t   o_wb_sel,
    output logic        o_wb_stb,
    output logic        o_iack,
    output logic        o_dack
);

    logic     r_lock;
    logic     r_lock_data;      // owner while locked
    logic     w_grant_data;
    bus_req_t w_req;

    assign w_grant_data = r_lock ? r_lock_data : i_dreq.stb;  // data first
    assign w_req = w_grant_data ? i_dreq : i_ireq;

    assign o_wb_adr = w_req.adr;
    assign o_wb_dat = w_req.dat;
    assign o_wb_we  = w_req.we;
    assign o_wb_sel = w_req.sel;
    assign o_wb_stb = w_req.stb;
    assign o_dack = i_wb_ack && w_grant_data;
    assign o_iack = i_wb_ack && !w_grant_data;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            r_lock <= 1'b0;
        else if (i_wb_ack)
            r_lock <= 1'b0;
        else if (w_req.stb)
            r_lock <= 1'b1;
    end

    always_ff @(posedge i_clk)
    begin
        if (!r_lock)
            r_lock_data <= w_grant_data;
    end

    // an ack only answers the requester that still holds its strobe
    assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |-> (o_dack && i_dreq.stb) || (o_iack && i_ireq.stb));

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
#(
    parameter addr_t RESET_ADDR = '0
)
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  xlen_t       i_wb_dat,
    input  logic        i_wb_ack,
    output addr_t       o_wb_adr,
    output xlen_t       o_wb_dat,
    output logic        o_wb_we,
    output byte_sel_t   o_wb_sel,
    output logic        o_wb_stb
);

    bus_req_t   w_ireq, w_dreq;
    logic       w_iack, w_dack;
    logic       w_instr_valid;
    instr_t     w_instr;
    addr_t      w_fetch_pc;
    logic       w_take, w_redirect, w_mem_start, w_mem_done, w_reg_we, w_taken;
    seq_state_e w_state;
    decoded_t   w_dec;
    xlen_t      w_rs1_val, w_rs2_val, w_result, w_load_val;
    addr_t      w_target;
    instr_t     r_ir;       // instruction in execution
    addr_t      r_pc;
    xlen_t      r_wb_val;

    always_ff @(posedge i_clk)
    begin
        if (w_take)
        begin
            r_ir <= w_instr;
            r_pc <= w_fetch_pc;
        end
        if (w_state == S_EXEC)
            r_wb_val <= w_result;
        else if (w_mem_done)
            r_wb_val <= w_load_val;     // load data replaces the address
    end

    rv_fetch #(.RESET_ADDR(RESET_ADDR)) u_rv_fetch
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_take(w_take), .i_redirect(w_redirect), .i_target(w_target),
        .i_rdata(i_wb_dat), .i_iack(w_iack), .o_ireq(w_ireq),
        .o_instr_valid(w_instr_valid), .o_instr(w_instr), .o_pc(w_fetch_pc)
    );

    rv_decode u_rv_decode (.i_instr(r_ir), .o_dec(w_dec));

    rv_regs u_rv_regs
    (
        .i_clk(i_clk),
        .i_rs1(w_dec.rs1), .i_rs2(w_dec.rs2), .i_rd(w_dec.rd),
        .i_we(w_reg_we), .i_wdata(r_wb_val),
        .o_rdata1(w_rs1_val), .o_rdata2(w_rs2_val)
    );

    rv_exec u_rv_exec
    (
        .i_dec(w_dec), .i_pc(r_pc), .i_rs1_val(w_rs1_val), .i_rs2_val(w_rs2_val),
        .o_result(w_result), .o_taken(w_taken), .o_target(w_target)
    );

    rv_lsu u_rv_lsu
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_start(w_mem_start), .i_dec(w_dec), .i_addr(w_result), .i_wdata(w_rs2_val),
        .i_rdata(i_wb_dat), .i_dack(w_dack), .o_dreq(w_dreq),
        .o_done(w_mem_done), .o_load_val(w_load_val)
    );

    rv_bus_arb u_rv_bus_arb
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_ireq(w_ireq), .i_dreq(w_dreq), .i_wb_ack(i_wb_ack),
        .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat), .o_wb_we(o_wb_we),
        .o_wb_sel(o_wb_sel), .o_wb_stb(o_wb_stb),
        .o_iack(w_iack), .o_dack(w_dack)
    );

    rv_seq u_rv_seq
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_instr_valid(w_instr_valid), .i_dec(w_dec), .i_taken(w_taken),
        .i_mem_done(w_mem_done),
        .o_take(w_take), .o_redirect(w_redirect), .o_mem_start(w_mem_start),
        .o_reg_we(w_reg_we), .o_state(w_state)
    );

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
    import rv_pkg::*;
(
    input  instr_t      i_instr,
    output decoded_t    o_dec
);

    xlen_t   w_imm_i, w_imm_s, w_imm_b, w_imm_u, w_imm_j;
    alu_op_e w_arith;
    logic    w_f7b5;

    assign w_f7b5  = i_instr[30];
    assign w_imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign w_imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign w_imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                      i_instr[11:8], 1'b0};
    assign w_imm_u = {i_instr[31:12], 12'b0};
    assign w_imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                      i_instr[30:21], 1'b0};

    // shared by op and op-imm
    always_comb
    begin
        case (i_instr[14:12])
            3'b000:  w_arith = (i_instr[5] && w_f7b5) ? ALU_SUB : ALU_ADD; // sub only for op
            3'b001:  w_arith = ALU_SLL;
            3'b010:  w_arith = ALU_SLT;
            3'b011:  w_arith = ALU_SLTU;
            3'b100:  w_arith = ALU_XOR;
            3'b101:  w_arith = w_f7b5 ? ALU_SRA : ALU_SRL;
            3'b110:  w_arith = ALU_OR;
            default: w_arith = ALU_AND;
        endcase
    end

    always_comb
    begin
        o_dec        = '0;
        o_dec.rs1    = i_instr[19:15];
        o_dec.rs2    = i_instr[24:20];
        o_dec.rd     = i_instr[11:7];
        o_dec.funct3 = i_instr[14:12];
        o_dec.alu_op = ALU_ADD;
        o_dec.wb_src = WB_ALU;
        case (i_instr[6:0])
            7'b0110111:     // lui
            begin
                o_dec.imm = w_imm_u;
                o_dec.alu_op = ALU_PASS_B;
                o_dec.op2_imm = 1'b1;
                o_dec.reg_write = 1'b1;
            end
            7'b0010111:     // auipc
            begin
                o_dec.imm = w_imm_u;
                o_dec.op1_pc = 1'b1;
                o_dec.op2_imm = 1'b1;
                o_dec.reg_write = 1'b1;
            end
            7'b1101111:     // jal
            begin
                o_dec.imm = w_imm_j;
                o_dec.jump = 1'b1;
                o_dec.reg_write = 1'b1;
                o_dec.wb_src = WB_PC4;
            end
            7'b1100111:     // jalr
            begin
                o_dec.imm = w_imm_i;
                o_dec.jump = 1'b1;
                o_dec.jalr = 1'b1;
                o_dec.reg_write = 1'b1;
                o_dec.wb_src = WB_PC4;
            end
            7'b1100011:
            begin
                o_dec.imm = w_imm_b;
                o_dec.branch = 1'b1;
            end
            7'b0000011:     // loads
            begin
                o_dec.imm = w_imm_i;
                o_dec.op2_imm = 1'b1;
                o_dec.mem_read = 1'b1;
                o_dec.reg_write = 1'b1;
                o_dec.wb_src = WB_LOAD;
            end
            7'b0100011:     // stores
            begin
                o_dec.imm = w_imm_s;
                o_dec.op2_imm = 1'b1;
                o_dec.mem_write = 1'b1;
            end
            7'b0010011:     // op-imm
            begin
                o_dec.imm = w_imm_i;
                o_dec.alu_op = w_arith;
                o_dec.op2_imm = 1'b1;
                o_dec.reg_write = 1'b1;
            end
            7'b0110011:
            begin
                o_dec.alu_op = w_arith;
                o_dec.reg_write = 1'b1;
            end
            default: ;      // nop
        endcase
    end

endmodule

// ==== logic/rv_exec.sv ====
`timescale 1ns/1ps

module rv_exec
    import rv_pkg::*;
(
    input  decoded_t    i_dec,
    input  addr_t       i_pc,
    input  xlen_t       i_rs1_val,
    input  xlen_t       i_rs2_val,
    output xlen_t       o_result,
    output logic        o_taken,
    output addr_t       o_target
);

    xlen_t w_op_a, w_op_b, w_alu;
    logic  w_cond;

    assign w_op_a = i_dec.op1_pc ? i_pc : i_rs1_val;
    assign w_op_b = i_dec.op2_imm ? i_dec.imm : i_rs2_val;

    always_comb
    begin
        case (i_dec.alu_op)
            ALU_SUB:    w_alu = w_op_a - w_op_b;
            ALU_SLL:    w_alu = w_op_a << w_op_b[4:0];
            ALU_SLT:    w_alu = {31'b0, $signed(w_op_a) < $signed(w_op_b)};
            ALU_SLTU:   w_alu = {31'b0, w_op_a < w_op_b};
            ALU_XOR:    w_alu = w_op_a ^ w_op_b;
            ALU_SRL:    w_alu = w_op_a >> w_op_b[4:0];
            ALU_SRA:    w_alu = $signed(w_op_a) >>> w_op_b[4:0];
            ALU_OR:     w_alu = w_op_a | w_op_b;
            ALU_AND:    w_alu = w_op_a & w_op_b;
            ALU_PASS_B: w_alu = w_op_b;
            default:    w_alu = w_op_a + w_op_b;
        endcase
    end

    always_comb
    begin
        case (i_dec.funct3)
            3'b000:  w_cond = i_rs1_val == i_rs2_val;
            3'b001:  w_cond = i_rs1_val != i_rs2_val;
            3'b100:  w_cond = $signed(i_rs1_val) < $signed(i_rs2_val);
            3'b101:  w_cond = $signed(i_rs1_val) >= $signed(i_rs2_val);
            3'b110:  w_cond = i_rs1_val < i_rs2_val;
            3'b111:  w_cond = i_rs1_val >= i_rs2_val;
            default: w_cond = 1'b0;
        endcase
    end

    assign o_result = (i_dec.wb_src == WB_PC4) ? i_pc + 32'd4 : w_alu;  // link value
    assign o_taken = (i_dec.branch && w_cond) || i_dec.jump;
    assign o_target = i_dec.jalr ? ((i_rs1_val + i_dec.imm) & ~32'd1) : i_pc + i_dec.imm;

endmodule

// ==== logic/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch
    import rv_pkg::*;
#(
    parameter addr_t RESET_ADDR = '0
)
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_take,
    input  logic        i_redirect,
    input  addr_t       i_target,
    input  xlen_t       i_rdata,
    input  logic        i_iack,
    output bus_req_t    o_ireq,
    output logic        o_instr_valid,
    output instr_t      o_instr,
    output addr_t       o_pc
);

    logic   r_busy;         // read on the bus
    logic   r_discard;      // in-flight word is stale
    logic   r_buf_valid;
    instr_t r_buf_instr;
    addr_t  r_buf_pc;       // tag of the buffered word
    addr_t  r_pc;           // next address to fetch
    addr_t  r_req_adr;
    addr_t  w_fetch_adr;
    logic   w_fill;
    logic   w_issue;

    assign w_fetch_adr = i_redirect ? i_target : r_pc;
    assign w_fill = i_iack && !r_discard && !i_redirect;
    // one word ahead only
    assign w_issue = (!r_busy || i_iack) && !w_fill &&
                     (!r_buf_valid || i_take || i_redirect);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_busy      <= 1'b0;
            r_discard   <= 1'b0;
            r_buf_valid <= 1'b0;
            r_pc        <= RESET_ADDR;
        end
        else
        begin
            if (i_iack)
                r_discard <= 1'b0;
            else if (i_redirect && r_busy)
                r_discard <= 1'b1;  // let it finish, drop the word

            if (w_fill)
                r_buf_valid <= 1'b1;
            else if (i_take || i_redirect)
                r_buf_valid <= 1'b0;

            if (w_issue)
            begin
                r_busy <= 1'b1;
                r_pc   <= w_fetch_adr + 32'd4;
            end
            else
            begin
                if (i_iack)
                    r_busy <= 1'b0;
                if (i_redirect)
                    r_pc <= i_target;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_issue)
            r_req_adr <= w_fetch_adr;
        if (w_fill)
        begin
            r_buf_instr <= i_rdata;
            r_buf_pc    <= r_req_adr;
        end
    end

    assign o_ireq = '{stb: r_busy, we: 1'b0, adr: r_req_adr, dat: '0, sel: 4'b1111};
    assign o_instr_valid = r_buf_valid;
    assign o_instr = r_buf_instr;
    assign o_pc = r_buf_pc;

    // address must not move under an unanswered read, even across a redirect
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_ireq.stb && !i_iack |=> o_ireq.stb && $stable(o_ireq.adr));

endmodule

// ==== logic/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu
    import rv_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_start,
    input  decoded_t    i_dec,
    input  addr_t       i_addr,
    input  xlen_t       i_wdata,
    input  xlen_t       i_rdata,
    input  logic        i_dack,
    output bus_req_t    o_dreq,
    output logic        o_done,
    output xlen_t       o_load_val
);

    logic       r_pending;
    logic       r_we;
    addr_t      r_adr;
    xlen_t      r_dat;
    byte_sel_t  r_sel;
    logic [2:0] r_funct3;
    logic [1:0] r_off;
    byte_sel_t  w_sel;
    xlen_t      w_dat;
    xlen_t      w_shifted;

    always_comb
    begin
        case (i_dec.funct3[1:0])
            2'b00:
            begin
                w_sel = 4'b0001 << i_addr[1:0];
                w_dat = {4{i_wdata[7:0]}};
            end
            2'b01:
            begin
                w_sel = i_addr[1] ? 4'b1100 : 4'b0011;
                w_dat = {2{i_wdata[15:0]}};
            end
            default:
            begin
                w_sel = 4'b1111;
                w_dat = i_wdata;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            r_pending <= 1'b0;
        else if (i_start)
            r_pending <= 1'b1;
        else if (i_dack)
            r_pending <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            r_we     <= i_dec.mem_write;
            r_adr    <= {i_addr[31:2], 2'b00};
            r_dat    <= w_dat;
            r_sel    <= w_sel;
            r_funct3 <= i_dec.funct3;
            r_off    <= i_addr[1:0];
        end
    end

    assign o_dreq = '{stb: r_pending, we: r_we, adr: r_adr, dat: r_dat, sel: r_sel};
    assign o_done = r_pending && i_dack;

    // addressed byte/half down to bit 0
    assign w_shifted = i_rdata >> {r_off, 3'b000};

    always_comb
    begin
        case (r_funct3)
            3'b000:  o_load_val = {{24{w_shifted[7]}}, w_shifted[7:0]};
            3'b001:  o_load_val = {{16{w_shifted[15]}}, w_shifted[15:0]};
            3'b100:  o_load_val = {24'b0, w_shifted[7:0]};
            3'b101:  o_load_val = {16'b0, w_shifted[15:0]};
            default: o_load_val = i_rdata;
        endcase
    end

    // sequencer must wait in S_MEM for the previous access
    assert property (@(posedge i_clk) disable iff (i_rst) i_start |-> !r_pending);

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_sel_t;

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_src_e;

    typedef enum logic [1:0] {S_FETCH, S_EXEC, S_MEM, S_WB} seq_state_e;

    typedef struct packed
    {
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        xlen_t      imm;
        alu_op_e    alu_op;
        logic       op1_pc;     // operand a is the pc
        logic       op2_imm;    // operand b is the immediate
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic [2:0] funct3;
        logic       branch;
        logic       jump;
        logic       jalr;
        wb_src_e    wb_src;
    } decoded_t;

    // one bus request, as seen by the arbiter
    typedef struct packed
    {
        logic       stb;
        logic       we;
        addr_t      adr;
        xlen_t      dat;
        byte_sel_t  sel;
    } bus_req_t;

endpackage

// ==== logic/rv_regs.sv ====
`timescale 1ns/1ps

module rv_regs
    import rv_pkg::*;
(
    input  logic        i_clk,
    input  reg_idx_t    i_rs1,
    input  reg_idx_t    i_rs2,
    input  reg_idx_t    i_rd,
    input  logic        i_we,
    input  xlen_t       i_wdata,
    output xlen_t       o_rdata1,
    output xlen_t       o_rdata2
);

    xlen_t r_mem [32];

    always_ff @(posedge i_clk)
    begin
        if (i_we && i_rd != '0)
            r_mem[i_rd] <= i_wdata;
    end

    // x0 is never written, so force it on read
    assign o_rdata1 = (i_rs1 == '0) ? '0 : r_mem[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : r_mem[i_rs2];

endmodule

// ==== logic/rv_seq.sv ====
`timescale 1ns/1ps

module rv_seq
    import rv_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_instr_valid,
    input  decoded_t    i_dec,
    input  logic        i_taken,
    input  logic        i_mem_done,
    output logic        o_take,
    output logic        o_redirect,
    output logic        o_mem_start,
    output logic        o_reg_we,
    output seq_state_e  o_state
);

    seq_state_e r_state;
    logic       w_mem_op;

    assign w_mem_op = i_dec.mem_read || i_dec.mem_write;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            r_state <= S_FETCH;
        else
        begin
            case (r_state)
                S_FETCH: if (i_instr_valid) r_state <= S_EXEC;
                S_EXEC:  r_state <= w_mem_op ? S_MEM : S_WB;
                S_MEM:   if (i_mem_done) r_state <= S_WB;
                default: r_state <= S_FETCH;
            endcase
        end
    end

    assign o_take = (r_state == S_FETCH) && i_instr_valid;
    assign o_redirect = (r_state == S_EXEC) && i_taken;
    assign o_mem_start = (r_state == S_EXEC) && w_mem_op;
    assign o_reg_we = (r_state == S_WB) && i_dec.reg_write;
    assign o_state = r_state;

endmodule

// ==== run.sh ====
#!/bin/sh
# builds and runs tb_rv_core with Verilator, pass or fail is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log && \
    verilator --binary --timing --assert --top-module tb_rv_core -f rv_core.f -o tb_rv_core && \
    ./obj_dir/tb_rv_core | tee sim.log
grep -q "^test passed$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== rv_core.f ====
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regs.sv
logic/rv_exec.sv
logic/rv_lsu.sv
logic/rv_bus_arb.sv
logic/rv_seq.sv
logic/rv_core.sv
testbench/tb_rv_core.sv

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam addr_t RESET_ADDR = 32'h0000_0000;
    localparam addr_t DATA_BASE  = 32'h0000_0200;
    localparam addr_t MEM_END    = 32'h0000_0400;  // 1 KiB model
    localparam int    MEM_WORDS  = 256;

    logic      clk;
    logic      rst;
    xlen_t     wb_rdata;
    logic      wb_ack;
    addr_t     wb_adr;
    xlen_t     wb_wdata;
    logic      wb_we;
    byte_sel_t wb_sel;
    logic      wb_stb;

    xlen_t  mem [MEM_WORDS];
    xlen_t  file_words [512];   // counts, program, then store records
    integer seed;
    integer rnd;
    integer prog_len;
    integer store_cnt;
    integer store_idx;
    integer wait_left;
    integer cycles;
    integer cycle_limit;
    logic   in_xfer;
    logic   first_seen;

    rv_core #(.RESET_ADDR(RESET_ADDR)) u_rv_core
    (
        .i_clk(clk), .i_rst(rst), .i_wb_dat(wb_rdata), .i_wb_ack(wb_ack),
        .o_wb_adr(wb_adr), .o_wb_dat(wb_wdata), .o_wb_we(wb_we),
        .o_wb_sel(wb_sel), .o_wb_stb(wb_stb)
    );

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_sel(input byte_sel_t got, input byte_sel_t exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // one bus access at the edge where ack is raised
    task automatic serve_access();
        integer idx;
        integer base;
        integer b;
        idx = int'(wb_adr[9:2]);
        if (!first_seen)
        begin
            first_seen = 1'b1;
            check_addr(wb_adr, RESET_ADDR, "first fetch address");
            check_flag(wb_we, 1'b0, "first fetch write enable");
            check_sel(wb_sel, 4'b1111, "first fetch select");
        end
        if (wb_adr >= MEM_END)
        begin
            $display("bus access at %h is outside the memory model", wb_adr);
            stop_run();
        end
        else if (wb_we && store_idx >= store_cnt)
        begin
            $display("a store to %h came after the last expected store", wb_adr);
            stop_run();
        end
        else if (wb_we && wb_adr < DATA_BASE)
        begin
            $display("store to %h falls outside the data region", wb_adr);
            stop_run();
        end
        else if (wb_we)
        begin
            base = 2 + prog_len + 3 * store_idx;
            check_addr(wb_adr, file_words[base], "store address");
            check_word(wb_wdata, file_words[base + 1], "store data");
            check_sel(wb_sel, byte_sel_t'(file_words[base + 2]), "store select");
            store_idx = store_idx + 1;
            for (b = 0; b < 4; b = b + 1)
                if (wb_sel[b])
                    mem[idx][8 * b +: 8] = wb_wdata[8 * b +: 8];
            wb_ack <= 1'b1;
        end
        else
        begin
            wb_rdata <= mem[idx];
            wb_ack   <= 1'b1;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
            in_xfer = 1'b0;
        end
        else
        begin
            cycles = cycles + 1;
            if (cycles > cycle_limit)
            begin
                $display("timeout after %0d cycles with %0d of %0d stores seen",
                         cycles, store_idx, store_cnt);
                stop_run();
            end
            else if (wb_ack)
            begin
                wb_ack <= 1'b0;     // access ends at this edge
                in_xfer = 1'b0;
            end
            else if (in_xfer && !wb_stb)
            begin
                $display("bus strobe dropped before its ack");
                stop_run();
            end
            else if (wb_stb)
            begin
                if (!in_xfer)
                begin
                    rnd = $random(seed);
                    wait_left = rnd & 3;
                    in_xfer = 1'b1;
                end
                if (wait_left == 0)
                    serve_access();
                else
                    wait_left = wait_left - 1;
            end
        end
    end

    initial
    begin
        integer i;
        seed = 32'h6cb5_4b43;
        rst <= 1'b1;
        wb_ack <= 1'b0;
        wb_rdata <= '0;
        in_xfer = 1'b0;
        first_seen = 1'b0;
        store_idx = 0;
        wait_left = 0;
        cycles = 0;
        $readmemh("testbench/tb_rv_core_input.txt", file_words);
        prog_len = int'(file_words[0]);
        store_cnt = int'(file_words[1]);
        cycle_limit = 40 * prog_len + 200;
        for (i = 0; i < MEM_WORDS; i = i + 1)
            mem[i] = (i < prog_len) ? file_words[2 + i] : 32'h5a00_0000 ^ (xlen_t'(i) << 2);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (store_idx < store_cnt)
            @(posedge clk);
        repeat (50) @(posedge clk);     // watch for a stray store
        $display("test passed");
        $finish;
    end

endmodule

// ==== testbench/tb_rv_core_input.txt ====
// first line: program word count, expected store count (hex)
// then program words from address 0, then one store per line: address data select
33 14
20000513 FFB00093 00300113 002081B3 00352023 401101B3 00352223 002091B3
00352423 0020D1B3 00352623 4010D193 00352823 0020A1B3 0020B233 00352A23
00452C23 123452B7 6782C293 00552E23 00001317 02652023 025504A3 02151723
02E51383 02E55403 02F50483 02954583 02752823 02852A23 02952C23 02B52E23
00110463 04252023 0020C463 04152223 0080066F 04152423 04C52623 0B000693
00068767 04152823 04152A23 04152C23 04E52E23 00117463 06D52023 00111463
06152223 06252423 0000006F
00000200 FFFFFFFE F
00000204 00000008 F
00000208 FFFFFFD8 F
0000020C 1FFFFFFF F
00000210 FFFFFFFD F
00000214 00000001 F
00000218 00000000 F
0000021C 12345678 F
00000220 00001050 F
00000228 78787878 2
0000022C FFFBFFFB C
00000230 FFFFFFFB F
00000234 0000FFFB F
00000238 FFFFFFFF F
0000023C 00000078 F
00000240 00000003 F
0000024C 00000094 F
0000025C 000000A4 F
00000260 000000B0 F
00000268 00000003 F
